/* verilog/edge_data_pkg.sv */
////////////////////////////////////////
// edge data fetch shared definitions
// widths, buffer depths, limits, controller
// states and the word byte swap
////////////////////////////////////////

package edge_data_pkg;

	////////////////////////////////////////
	// data path widths
	////////////////////////////////////////

	localparam int vertex_index_w = 32;
	localparam int address_w      = 64;
	localparam int data_word_w    = 32;

	// one beat carries half of a 128 byte line
	localparam int half_line_w    = 512;
	localparam int words_per_half = 16;

	// word position 0 to 31 inside the full line
	localparam int word_offset_w  = 5;

	////////////////////////////////////////
	// buffering and flow control
	////////////////////////////////////////

	localparam int job_buffer_depth     = 16;
	localparam int buffer_alfull_margin = 2;

	// reads in flight before command issue stalls
	localparam int max_outstanding = 12;
	localparam int outstanding_w   = 4;

	////////////////////////////////////////
	// controller states
	////////////////////////////////////////

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain
	} fetch_state;

	// memory returns big endian words
	function automatic logic [data_word_w-1:0] swap_word_bytes(
		input logic [data_word_w-1:0] word
	);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

endpackage

/* verilog/sync_fifo.sv */
////////////////////////////////////////
// synchronous register FIFO
// first word fall through output
////////////////////////////////////////

module sync_fifo #(
	parameter int width = 32,
	parameter int depth = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [width-1:0] data_in,
	input  logic             pop,
	output logic [width-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);
	import edge_data_pkg::*;

	localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_w = $clog2(depth + 1);

	logic [width-1:0]   mem [depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [count_w-1:0] count;

	// wrap explicitly so any depth works
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// head entry is visible before the pop
	assign data_out = mem[rd_ptr];
	assign full     = (count == count_w'(depth));
	assign alfull   = (count >= count_w'(depth - buffer_alfull_margin));
	assign empty    = (count == '0);

	no_overflow: assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("push into a full fifo");
	no_underflow: assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("pop from an empty fifo");

endmodule

/* verilog/outstanding_read_counter.sv */
////////////////////////////////////////
// outstanding read counter
// issued reads minus responses
////////////////////////////////////////

module outstanding_read_counter (
	input  logic clock,
	input  logic rstn,
	input  logic issue,
	input  logic response,
	output logic at_limit,
	output logic none_outstanding
);
	import edge_data_pkg::*;

	logic [outstanding_w-1:0] count;

	// both strobes together leave the count alone
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= '0;
		end else begin
			case ({issue, response})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign at_limit         = (count == outstanding_w'(max_outstanding));
	assign none_outstanding = (count == '0);

	no_orphan_response: assert property (@(posedge clock) disable iff (!rstn)
		(response && !issue) |-> !none_outstanding)
		else $error("read response with no read outstanding");
	limit_respected: assert property (@(posedge clock) disable iff (!rstn)
		(issue && !response) |-> !at_limit)
		else $error("read issued past the outstanding limit");

endmodule

/* verilog/edge_fetch_fsm.sv */
////////////////////////////////////////
// edge fetch controller
// run while enabled, drain in flight reads
////////////////////////////////////////

module edge_fetch_fsm (
	input  logic clock,
	input  logic rstn,
	input  logic enabled_in,
	input  logic none_outstanding,
	input  logic job_empty,
	input  logic cmd_empty,
	output logic intake_enable,
	output logic issue_enable,
	output logic busy
);
	import edge_data_pkg::*;

	fetch_state state;
	fetch_state state_next;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (enabled_in) begin
					state_next = st_run;
				end
			end
			st_run: begin
				if (!enabled_in) begin
					state_next = st_drain;
				end
			end
			st_drain: begin
				// everything accepted must be issued and answered first
				if (none_outstanding && job_empty && cmd_empty) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	assign intake_enable = (state == st_run);
	assign issue_enable  = (state == st_run) || (state == st_drain);
	assign busy          = (state != st_idle);

	busy_while_outstanding: assert property (@(posedge clock) disable iff (!rstn)
		!none_outstanding |-> busy)
		else $error("controller idle with reads still in flight");

endmodule

/* verilog/edge_read_issue.sv */
////////////////////////////////////////
// edge read issue
// job buffer, address and offset forming,
// read command buffer with flow control
////////////////////////////////////////

module edge_read_issue (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    intake_enable,
	input  logic                                    issue_enable,
	input  logic [edge_data_pkg::address_w-1:0]     data_base_address,
	input  logic                                    edge_valid,
	input  logic [edge_data_pkg::vertex_index_w-1:0] edge_dest,
	input  logic                                    read_buffer_alfull,
	input  logic                                    at_limit,
	output logic                                    edge_request,
	output logic                                    job_empty,
	output logic                                    cmd_empty,
	output logic                                    read_cmd_valid,
	output logic [edge_data_pkg::address_w-1:0]     read_cmd_address,
	output logic [edge_data_pkg::word_offset_w-1:0] read_cmd_offset
);
	import edge_data_pkg::*;

	localparam int cmd_w = address_w + word_offset_w;

	logic                      job_latch_valid;
	logic [vertex_index_w-1:0] job_latch_dest;
	logic [vertex_index_w-1:0] job_head;
	logic                      job_fifo_empty;
	logic                      job_alfull;
	logic                      job_pop;
	logic [address_w-1:0]      job_address;
	logic                      cmd_pend_valid;
	logic [cmd_w-1:0]          cmd_pend;
	logic [cmd_w-1:0]          cmd_head;
	logic                      cmd_fifo_empty;
	logic                      cmd_alfull;
	logic                      cmd_pop;

	////////////////////////////////////////
	// job intake
	////////////////////////////////////////

	assign edge_request = intake_enable && !job_alfull;

	// late jobs after disable are still taken
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_latch_valid <= 1'b0;
		end else begin
			job_latch_valid <= edge_valid;
		end
	end

	always_ff @(posedge clock) begin
		job_latch_dest <= edge_dest;
	end

	sync_fifo #(.width(vertex_index_w), .depth(job_buffer_depth)) job_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (job_latch_valid),
		.data_in  (job_latch_dest),
		.pop      (job_pop),
		.data_out (job_head),
		.full     (),
		.alfull   (job_alfull),
		.empty    (job_fifo_empty)
	);

	// a job on the port or in the latch counts as pending
	assign job_empty = job_fifo_empty && !job_latch_valid && !edge_valid;

	////////////////////////////////////////
	// command forming
	////////////////////////////////////////

	assign job_pop     = !job_fifo_empty && !cmd_alfull && issue_enable;
	// four bytes per vertex entry
	assign job_address = data_base_address + (address_w'(job_head) << 2);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_pend_valid <= 1'b0;
		end else begin
			cmd_pend_valid <= job_pop;
		end
	end

	// word position inside the 128 byte line
	always_ff @(posedge clock) begin
		cmd_pend <= {job_address, job_address[word_offset_w+1:2]};
	end

	////////////////////////////////////////
	// command buffer
	////////////////////////////////////////

	sync_fifo #(.width(cmd_w), .depth(job_buffer_depth)) cmd_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (cmd_pend_valid),
		.data_in  (cmd_pend),
		.pop      (cmd_pop),
		.data_out (cmd_head),
		.full     (),
		.alfull   (cmd_alfull),
		.empty    (cmd_fifo_empty)
	);

	assign cmd_empty = cmd_fifo_empty && !cmd_pend_valid;
	assign cmd_pop   = !cmd_fifo_empty && !read_buffer_alfull && !at_limit;

	// head goes out the same cycle it is popped
	assign read_cmd_valid                      = cmd_pop;
	assign {read_cmd_address, read_cmd_offset} = cmd_head;

endmodule

/* verilog/cacheline_word_extract.sv */
////////////////////////////////////////
// cacheline word extract
// half line select, word pick, endian
// swap and the edge data buffer
////////////////////////////////////////

module cacheline_word_extract (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    read_data_0_valid,
	input  logic [edge_data_pkg::half_line_w-1:0]   read_data_0,
	input  logic [edge_data_pkg::word_offset_w-1:0] read_data_0_offset,
	input  logic                                    read_data_1_valid,
	input  logic [edge_data_pkg::half_line_w-1:0]   read_data_1,
	input  logic [edge_data_pkg::word_offset_w-1:0] read_data_1_offset,
	input  logic                                    edge_data_request,
	output logic                                    edge_data_valid,
	output logic [edge_data_pkg::data_word_w-1:0]   edge_data,
	output logic                                    data_buffer_empty,
	output logic                                    data_buffer_full
);
	import edge_data_pkg::*;

	localparam int word_index_w = $clog2(words_per_half);

	logic                     beat0_valid;
	logic                     beat1_valid;
	logic [half_line_w-1:0]   beat0_data;
	logic [half_line_w-1:0]   beat1_data;
	logic [word_offset_w-1:0] beat0_offset;
	logic [word_offset_w-1:0] beat1_offset;
	logic                     take0;
	logic                     take1;
	logic [half_line_w-1:0]   half_sel;
	logic [word_index_w-1:0]  word_index;
	logic                     pick_valid;
	logic [data_word_w-1:0]   pick_word;
	logic                     swap_valid;
	logic [data_word_w-1:0]   swap_word;
	logic [data_word_w-1:0]   fifo_head;
	logic                     fifo_pop;

	////////////////////////////////////////
	// input latch
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			beat0_valid <= 1'b0;
			beat1_valid <= 1'b0;
		end else begin
			beat0_valid <= read_data_0_valid;
			beat1_valid <= read_data_1_valid;
		end
	end

	always_ff @(posedge clock) begin
		beat0_data   <= read_data_0;
		beat0_offset <= read_data_0_offset;
		beat1_data   <= read_data_1;
		beat1_offset <= read_data_1_offset;
	end

	////////////////////////////////////////
	// half select and word pick
	////////////////////////////////////////

	// port 0 holds words 0-15, port 1 words 16-31
	assign take0      = beat0_valid && !beat0_offset[word_offset_w-1];
	assign take1      = beat1_valid && beat1_offset[word_offset_w-1];
	assign half_sel   = take0 ? beat0_data : beat1_data;
	assign word_index = take0 ? beat0_offset[word_index_w-1:0] : beat1_offset[word_index_w-1:0];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pick_valid <= 1'b0;
			swap_valid <= 1'b0;
		end else begin
			pick_valid <= take0 || take1;
			swap_valid <= pick_valid;
		end
	end

	// word k sits at bits 32k and up within the beat
	always_ff @(posedge clock) begin
		pick_word <= half_sel[word_index*data_word_w +: data_word_w];
		swap_word <= swap_word_bytes(pick_word);
	end

	////////////////////////////////////////
	// edge data buffer
	////////////////////////////////////////

	sync_fifo #(.width(data_word_w), .depth(job_buffer_depth)) data_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (swap_valid),
		.data_in  (swap_word),
		.pop      (fifo_pop),
		.data_out (fifo_head),
		.full     (data_buffer_full),
		.alfull   (),
		.empty    (data_buffer_empty)
	);

	assign fifo_pop = edge_data_request && !data_buffer_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data_valid <= 1'b0;
		end else begin
			edge_data_valid <= fifo_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (fifo_pop) begin
			edge_data <= fifo_head;
		end
	end

endmodule

/* verilog/edge_data_control.sv */
////////////////////////////////////////
// edge data control, compute unit stage
// fetches one data word per edge job
////////////////////////////////////////

module edge_data_control (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    enabled_in,
	input  logic [edge_data_pkg::address_w-1:0]     data_base_address,
	output logic                                    edge_request,
	input  logic                                    edge_valid,
	input  logic [edge_data_pkg::vertex_index_w-1:0] edge_dest,
	input  logic                                    read_buffer_alfull,
	output logic                                    read_cmd_valid,
	output logic [edge_data_pkg::address_w-1:0]     read_cmd_address,
	output logic [edge_data_pkg::word_offset_w-1:0] read_cmd_offset,
	input  logic                                    read_response_valid,
	input  logic                                    read_data_0_valid,
	input  logic [edge_data_pkg::half_line_w-1:0]   read_data_0,
	input  logic [edge_data_pkg::word_offset_w-1:0] read_data_0_offset,
	input  logic                                    read_data_1_valid,
	input  logic [edge_data_pkg::half_line_w-1:0]   read_data_1,
	input  logic [edge_data_pkg::word_offset_w-1:0] read_data_1_offset,
	input  logic                                    edge_data_request,
	output logic                                    edge_data_valid,
	output logic [edge_data_pkg::data_word_w-1:0]   edge_data,
	output logic                                    data_buffer_empty,
	output logic                                    data_buffer_full,
	output logic                                    busy
);

	logic intake_enable;
	logic issue_enable;
	logic job_empty;
	logic cmd_empty;
	logic at_limit;
	logic none_outstanding;

	edge_fetch_fsm fsm (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.none_outstanding (none_outstanding),
		.job_empty        (job_empty),
		.cmd_empty        (cmd_empty),
		.intake_enable    (intake_enable),
		.issue_enable     (issue_enable),
		.busy             (busy)
	);

	// each command leaving counts as one read in flight
	outstanding_read_counter read_counter (
		.clock            (clock),
		.rstn             (rstn),
		.issue            (read_cmd_valid),
		.response         (read_response_valid),
		.at_limit         (at_limit),
		.none_outstanding (none_outstanding)
	);

	edge_read_issue read_issue (
		.clock              (clock),
		.rstn               (rstn),
		.intake_enable      (intake_enable),
		.issue_enable       (issue_enable),
		.data_base_address  (data_base_address),
		.edge_valid         (edge_valid),
		.edge_dest          (edge_dest),
		.read_buffer_alfull (read_buffer_alfull),
		.at_limit           (at_limit),
		.edge_request       (edge_request),
		.job_empty          (job_empty),
		.cmd_empty          (cmd_empty),
		.read_cmd_valid     (read_cmd_valid),
		.read_cmd_address   (read_cmd_address),
		.read_cmd_offset    (read_cmd_offset)
	);

	cacheline_word_extract word_extract (
		.clock              (clock),
		.rstn               (rstn),
		.read_data_0_valid  (read_data_0_valid),
		.read_data_0        (read_data_0),
		.read_data_0_offset (read_data_0_offset),
		.read_data_1_valid  (read_data_1_valid),
		.read_data_1        (read_data_1),
		.read_data_1_offset (read_data_1_offset),
		.edge_data_request  (edge_data_request),
		.edge_data_valid    (edge_data_valid),
		.edge_data          (edge_data),
		.data_buffer_empty  (data_buffer_empty),
		.data_buffer_full   (data_buffer_full)
	);

endmodule

/* verif/edge_data_control_tb.sv */
////////////////////////////////////////
// edge data control testbench
// random edge jobs, memory responder,
// reference model and status checks
////////////////////////////////////////

module edge_data_control_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import edge_data_pkg::*;

	localparam int jobs_run    = 60;
	localparam int jobs_fill   = 24;
	localparam int jobs_drain  = 20;
	localparam int total_jobs  = jobs_run + jobs_fill + jobs_drain;
	localparam int watchdog_cycles = total_jobs * 200 + 2000;

	logic                      clock;
	logic                      rstn;
	logic                      enabled_in;
	logic [address_w-1:0]      data_base_address;
	logic                      edge_request;
	logic                      edge_valid;
	logic [vertex_index_w-1:0] edge_dest;
	logic                      read_buffer_alfull;
	logic                      read_cmd_valid;
	logic [address_w-1:0]      read_cmd_address;
	logic [word_offset_w-1:0]  read_cmd_offset;
	logic                      read_response_valid;
	logic                      read_data_0_valid;
	logic [half_line_w-1:0]    read_data_0;
	logic [word_offset_w-1:0]  read_data_0_offset;
	logic                      read_data_1_valid;
	logic [half_line_w-1:0]    read_data_1;
	logic [word_offset_w-1:0]  read_data_1_offset;
	logic                      edge_data_request;
	logic                      edge_data_valid;
	logic [data_word_w-1:0]    edge_data;
	logic                      data_buffer_empty;
	logic                      data_buffer_full;
	logic                      busy;

	// reference model state
	logic [address_w-1:0]   exp_cmd [$];
	logic [address_w-1:0]   pend_addr [$];
	int                     pend_due [$];
	logic [data_word_w-1:0] exp_data [$];
	int  cycle_count   = 0;
	int  jobs_left     = 0;
	int  outstanding   = 0;
	int  buffered      = 0;
	int  resp_count    = 0;
	int  pop_count     = 0;
	int  low_seen      = 0;
	int  high_seen     = 0;
	bit  pop_pending   = 0;
	bit  consume_hold  = 0;
	bit  intake_closed = 0;
	bit [2:0] push_pipe = '0;

	edge_data_control edge_data_control_inst (.*);

	always #4 clock = ~clock;

	////////////////////////////////////////
	// compare tasks and helpers
	////////////////////////////////////////

	task automatic check_command(input logic [address_w-1:0] got_address,
		input logic [address_w-1:0] exp_address, input logic [word_offset_w-1:0] got_offset,
		input logic [word_offset_w-1:0] exp_offset);
		if (got_address !== exp_address || got_offset !== exp_offset) begin
			$display("ERROR at %0t: read command got %h/%0d expected %h/%0d", $time,
				got_address, got_offset, exp_address, exp_offset);
			$display("RESULT: FAIL");
			$fatal(1, "read command mismatch");
		end
	endtask

	task automatic check_edge_data(input logic [data_word_w-1:0] got,
		input logic [data_word_w-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: edge data got %h expected %h", $time, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "edge data mismatch");
		end
	endtask

	task automatic check_state_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "status level mismatch");
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "testbench stopped");
	endtask

	// little endian value of each line word from the whole address
	function automatic logic [data_word_w-1:0] line_word(input logic [address_w-1:0] addr,
		input int idx);
		logic [address_w-1:0] line;
		line = addr >> 7;
		return line[31:0] ^ (line[63:32] * 32'd40503) ^ (32'(idx) * 32'h9e3779b1);
	endfunction

	function automatic bit all_settled();
		return jobs_left == 0 && exp_cmd.size() == 0 && pend_addr.size() == 0 &&
			exp_data.size() == 0 && buffered == 0 && !pop_pending && outstanding == 0;
	endfunction

	////////////////////////////////////////
	// stimulus processes
	////////////////////////////////////////

	// job source sends only after edge_request in the previous cycle
	always @(posedge clock) begin
		logic                      req_seen;
		logic [vertex_index_w-1:0] dest;
		req_seen = edge_request;
		#1;
		if (jobs_left > 0 && req_seen && $urandom_range(3) != 0) begin
			dest       = $urandom();
			edge_valid = 1'b1;
			edge_dest  = dest;
			exp_cmd.push_back(data_base_address + (address_w'(dest) << 2));
			jobs_left--;
		end else begin
			edge_valid = 1'b0;
		end
	end

	// consumer and external back pressure
	always @(posedge clock) begin
		#1;
		edge_data_request  = consume_hold ? 1'b0 : 1'(($urandom_range(1)));
		read_buffer_alfull = ($urandom_range(3) == 0);
	end

	// memory responder answers in issue order within the data buffer room
	always @(posedge clock) begin
		logic [address_w-1:0]     addr;
		logic [word_offset_w-1:0] offset;
		logic [half_line_w-1:0]   beat;
		logic [data_word_w-1:0]   be_word;
		#1;
		read_response_valid = 1'b0;
		read_data_0_valid   = 1'b0;
		read_data_1_valid   = 1'b0;
		if (rstn && pend_addr.size() > 0 && pend_due[0] <= cycle_count &&
			(resp_count - pop_count) < job_buffer_depth) begin
			addr   = pend_addr.pop_front();
			void'(pend_due.pop_front());
			offset = addr[word_offset_w+1:2];
			for (int k = 0; k < words_per_half; k++) begin
				be_word = {<<8{line_word(addr, (offset[4] ? 16 : 0) + k)}};
				beat[k*data_word_w +: data_word_w] = be_word;
			end
			read_response_valid = 1'b1;
			exp_data.push_back(line_word(addr, offset));
			resp_count++;
			if (offset[4]) begin
				high_seen++;
				read_data_1_valid  = 1'b1;
				read_data_1        = beat;
				read_data_1_offset = offset;
				// junk on the other port that must be ignored
				read_data_0_valid  = ($urandom_range(2) == 0);
				read_data_0        = ~beat;
				read_data_0_offset = offset;
			end else begin
				low_seen++;
				read_data_0_valid  = 1'b1;
				read_data_0        = beat;
				read_data_0_offset = offset;
				read_data_1_valid  = ($urandom_range(2) == 0);
				read_data_1        = ~beat;
				read_data_1_offset = offset;
			end
		end
	end

	////////////////////////////////////////
	// monitor and model update
	////////////////////////////////////////

	always @(posedge clock) begin
		logic [address_w-1:0] exp_address;
		bit qualifies;
		bit push_now;
		bit pop_now;
		if (rstn) begin
			cycle_count++;
			check_state_level("data_buffer_empty", data_buffer_empty, buffered == 0);
			check_state_level("data_buffer_full", data_buffer_full,
				buffered == job_buffer_depth);
			if (outstanding > 0 || exp_cmd.size() > 0) begin
				check_state_level("busy", busy, 1'b1);
			end
			if (intake_closed) begin
				check_state_level("edge_request", edge_request, 1'b0);
			end
			// popped word shows one cycle after the request
			if (pop_pending) begin
				check_state_level("edge_data_valid", edge_data_valid, 1'b1);
				if (exp_data.size() == 0) begin
					report_failure("edge data returned while no word was expected");
				end
				check_edge_data(edge_data, exp_data.pop_front());
			end else begin
				check_state_level("edge_data_valid", edge_data_valid, 1'b0);
			end
			if (read_cmd_valid) begin
				if (exp_cmd.size() == 0) begin
					report_failure("read command issued with no edge job waiting for it");
				end
				exp_address = exp_cmd.pop_front();
				check_command(read_cmd_address, exp_address, read_cmd_offset,
					exp_address[word_offset_w+1:2]);
				pend_addr.push_back(exp_address);
				pend_due.push_back(cycle_count + 2 + $urandom_range(18));
				outstanding++;
			end
			if (read_response_valid) begin
				outstanding--;
			end
			if (outstanding > max_outstanding) begin
				report_failure("more unanswered read commands than the outstanding limit");
			end
			// a qualifying beat lands its word three edges later
			qualifies = (read_data_0_valid && !read_data_0_offset[4]) ||
				(read_data_1_valid && read_data_1_offset[4]);
			push_now  = push_pipe[2];
			push_pipe = {push_pipe[1:0], qualifies};
			pop_now   = edge_data_request && !data_buffer_empty;
			buffered  = buffered + int'(push_now) - int'(pop_now);
			pop_pending = pop_now;
			pop_count   = pop_count + int'(pop_now);
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(32'h48e0));
		clock               = 1'b0;
		rstn                = 1'b0;
		enabled_in          = 1'b0;
		data_base_address   = {$urandom(), $urandom()} & ~64'h3;
		edge_valid          = 1'b0;
		edge_dest           = '0;
		read_buffer_alfull  = 1'b0;
		read_response_valid = 1'b0;
		read_data_0_valid   = 1'b0;
		read_data_0         = '0;
		read_data_0_offset  = '0;
		read_data_1_valid   = 1'b0;
		read_data_1         = '0;
		read_data_1_offset  = '0;
		edge_data_request   = 1'b0;

		repeat (8) @(posedge clock);
		check_state_level("edge_request", edge_request, 1'b0);
		check_state_level("read_cmd_valid", read_cmd_valid, 1'b0);
		check_state_level("edge_data_valid", edge_data_valid, 1'b0);
		check_state_level("busy", busy, 1'b0);
		check_state_level("data_buffer_empty", data_buffer_empty, 1'b1);
		#1;
		rstn = 1'b1;

		// random traffic with back pressure and slow memory
		@(posedge clock);
		#1;
		enabled_in = 1'b1;
		jobs_left  = jobs_run;
		while (!all_settled()) @(negedge clock);

		// consumer stalled until the data buffer fills
		consume_hold = 1'b1;
		jobs_left    = jobs_fill;
		while (!data_buffer_full) @(posedge clock);
		repeat (10) @(posedge clock);
		@(negedge clock);
		consume_hold = 1'b0;
		while (!all_settled()) @(negedge clock);

		// disable with reads still in flight
		jobs_left = jobs_drain;
		while (jobs_left > 0) @(posedge clock);
		@(posedge clock);
		#1;
		enabled_in = 1'b0;
		@(posedge clock);
		#1;
		intake_closed = 1'b1;
		while (!all_settled() || busy) @(negedge clock);
		repeat (4) @(posedge clock);
		check_state_level("busy", busy, 1'b0);

		if (low_seen > 0 && high_seen > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("run ended without words from both half lines");
			$display("RESULT: FAIL");
			$fatal(1, "incomplete run");
		end
	end

	// hang guard
	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, the run is hung", watchdog_cycles);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

endmodule

/* edge_data_control.f */
verilog/edge_data_pkg.sv
verilog/sync_fifo.sv
verilog/outstanding_read_counter.sv
verilog/edge_fetch_fsm.sv
verilog/edge_read_issue.sv
verilog/cacheline_word_extract.sv
verilog/edge_data_control.sv
verif/edge_data_control_tb.sv

/* Bender.yml */
package:
  name: edge_data_control

sources:
  # shared package first
  - verilog/edge_data_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/outstanding_read_counter.sv
  - verilog/edge_fetch_fsm.sv
  - verilog/edge_read_issue.sv
  - verilog/cacheline_word_extract.sv
  - verilog/edge_data_control.sv

  - target: test
    files:
      - verif/edge_data_control_tb.sv
